// File: build.f
rtl/codec_regs_pkg.sv
rtl/apb_map_pkg.sv
rtl/apb_codec_decode.sv
rtl/codec_frame_scheduler.sv
rtl/spi_frame_shifter.sv
rtl/codec_ctrl_top.sv
verification/codec_ctrl_properties.sv
verification/tb_codec_ctrl.sv

// File: rtl/apb_codec_decode.sv
// APB slave for the codec controller
// Keeps gain shadows, drops unchanged gains, hands the rest to the scheduler
`timescale 1ns/1ps

module apb_codec_decode (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               cmd_valid,
  output apb_map_pkg::cmd_kind_e             cmd_kind,
  output logic [12:0]                        cmd_value,
  input  logic                               cmd_ready,
  input  logic                               init_done,
  input  logic                               busy
);

  import apb_map_pkg::*;
  import codec_regs_pkg::*;

  logic       access;
  logic       is_tx, is_rx, is_raw, is_stat;
  logic       acc_err;
  logic       tx_changed, rx_changed;
  logic [3:0] tx_shadow;   // Last gain sent to the codec
  logic [6:0] rx_shadow;

  assign access = psel & penable;

  // Offset classification
  assign is_tx   = (paddr == OFF_TX_GAIN);
  assign is_rx   = (paddr == OFF_RX_GAIN);
  assign is_raw  = (paddr == OFF_RAW);
  assign is_stat = (paddr == OFF_STATUS);
  assign acc_err = !(is_tx | is_rx | is_raw | is_stat) | (pwrite & is_stat);

  assign tx_changed = (pwdata[3:0] != tx_shadow);
  assign rx_changed = (pwdata[6:0] != rx_shadow);

  // Only writes that change something reach the SPI side
  assign cmd_valid = access & pwrite &
                     ((is_tx & tx_changed) | (is_rx & rx_changed) | is_raw);

  always_comb begin
    cmd_kind  = CMD_RAW;
    cmd_value = pwdata[12:0];   // Raw: addr 12:8, data 7:0
    if (is_tx) begin
      cmd_kind  = CMD_TX_GAIN;
      cmd_value = {9'd0, pwdata[3:0]};
    end else if (is_rx) begin
      cmd_kind  = CMD_RX_GAIN;
      cmd_value = {6'd0, pwdata[6:0]};
    end
  end

  // Wait states until the scheduler takes the command
  assign pready  = access & (!cmd_valid | cmd_ready);
  assign pslverr = access & acc_err;

  always_comb begin
    prdata = '0;
    if (is_tx) prdata[3:0] = tx_shadow;
    if (is_rx) prdata[6:0] = rx_shadow;
    if (is_stat) begin
      prdata[STAT_INIT_DONE] = init_done;
      prdata[STAT_BUSY]      = busy;
    end
  end

  // Shadow commit on the handshake cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_shadow <= TX_GAIN_RESET;
      rx_shadow <= RX_GAIN_RESET;
    end else if (cmd_valid && cmd_ready) begin
      case (cmd_kind)
        CMD_TX_GAIN: tx_shadow <= cmd_value[3:0];
        CMD_RX_GAIN: rx_shadow <= cmd_value[6:0];
        default: ;              // Raw writes leave gains alone
      endcase
    end
  end

endmodule

// File: rtl/apb_map_pkg.sv
// APB register map of the codec controller
// Offsets, command kinds and status bits
package apb_map_pkg;

  localparam int APB_ADDR_W = 4;

  localparam logic [APB_ADDR_W-1:0] OFF_TX_GAIN = 4'h0;
  localparam logic [APB_ADDR_W-1:0] OFF_RX_GAIN = 4'h4;
  localparam logic [APB_ADDR_W-1:0] OFF_RAW     = 4'h8;
  localparam logic [APB_ADDR_W-1:0] OFF_STATUS  = 4'hC; // Read only

  // Command kinds passed to the frame scheduler
  typedef enum logic [1:0] {
    CMD_TX_GAIN = 2'd0,
    CMD_RX_GAIN = 2'd1,
    CMD_RAW     = 2'd2
  } cmd_kind_e;

  // Status register bits
  localparam int STAT_INIT_DONE = 0;
  localparam int STAT_BUSY      = 1;

endpackage

// File: rtl/codec_ctrl_top.sv
// AD9866 serial port controller top
// APB decode, frame scheduler and SPI shifter
`timescale 1ns/1ps

module codec_ctrl_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               sen_n,
  output logic                               sclk,
  output logic                               sdio
);

  import apb_map_pkg::*;
  import codec_regs_pkg::*;

  logic                  cmd_valid, cmd_ready;
  cmd_kind_e             cmd_kind;
  logic [12:0]           cmd_value;
  logic                  init_done, busy;
  logic                  frame_start;
  logic [FRAME_BITS-1:0] frame_word;

  apb_codec_decode apb_codec_decode_inst (.*);

  codec_frame_scheduler codec_frame_scheduler_inst (.*);

  spi_frame_shifter spi_frame_shifter_inst (.*);

endmodule

// File: rtl/codec_frame_scheduler.sv
// Codec frame scheduler
// Sends the init table after reset, then turns commands into SPI words
`timescale 1ns/1ps

module codec_frame_scheduler (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cmd_valid,
  input  apb_map_pkg::cmd_kind_e                 cmd_kind,
  input  logic [12:0]                            cmd_value,
  output logic                                   cmd_ready,
  output logic                                   init_done,
  output logic                                   frame_start,
  output logic [codec_regs_pkg::FRAME_BITS-1:0]  frame_word,
  input  logic                                   busy
);

  import apb_map_pkg::*;
  import codec_regs_pkg::*;

  logic [REG_ADDR_W-1:0] init_idx;   // Table index doubles as codec address
  logic [REG_DATA_W:0]   init_entry;
  logic                  busy_d;
  logic                  launch_ok;
  logic [5:0]            rx_code;
  logic [FRAME_BITS-1:0] cmd_frame;

  // One idle cycle after busy drops before the next frame
  assign launch_ok = !busy && !busy_d && !frame_start;
  assign cmd_ready = init_done && launch_ok;

  assign init_entry = (init_idx < INIT_LEN) ? INIT_TABLE[init_idx] : '0;

  // RX gain remap to the 6-bit PGA code
  always_comb begin
    if (cmd_value[6])
      rx_code = cmd_value[5:0];
    else if (cmd_value[5])
      rx_code = ~cmd_value[5:0];
    else
      rx_code = {1'b1, cmd_value[4:0]};
  end

  always_comb begin
    case (cmd_kind)
      CMD_TX_GAIN: cmd_frame = {{FRAME_PAD_W{1'b0}}, REG_TX_GAIN, TX_GAIN_PREFIX,
                                cmd_value[3:0]};
      CMD_RX_GAIN: cmd_frame = {{FRAME_PAD_W{1'b0}}, REG_RX_GAIN, RX_GAIN_PREFIX,
                                rx_code};
      default:     cmd_frame = {{FRAME_PAD_W{1'b0}}, cmd_value};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_idx    <= '0;
      init_done   <= 1'b0;
      frame_start <= 1'b0;
      busy_d      <= 1'b0;
    end else begin
      busy_d      <= busy;
      frame_start <= 1'b0;     // Single-cycle pulse
      if (!init_done) begin
        if (init_idx == INIT_LEN) begin
          if (launch_ok) init_done <= 1'b1;  // Last init frame finished
        end else if (!init_entry[REG_DATA_W]) begin
          init_idx <= init_idx + 1'b1;        // Skip disabled entry
        end else if (launch_ok) begin
          frame_start <= 1'b1;
          init_idx    <= init_idx + 1'b1;
        end
      end else if (cmd_valid && cmd_ready) begin
        frame_start <= 1'b1;
      end
    end
  end

  // Frame payload, loaded with each launch
  always_ff @(posedge clk) begin
    if (!init_done && init_entry[REG_DATA_W] && launch_ok)
      frame_word <= {{FRAME_PAD_W{1'b0}}, init_idx, init_entry[REG_DATA_W-1:0]};
    else if (cmd_valid && cmd_ready)
      frame_word <= cmd_frame;
  end

endmodule

// File: rtl/codec_regs_pkg.sv
// AD9866 codec register map and init write table
// Frame layout is 3 zero bits, 5-bit address, 8 data bits, MSB first
package codec_regs_pkg;

  localparam int FRAME_BITS  = 16;
  localparam int REG_ADDR_W  = 5;
  localparam int REG_DATA_W  = 8;
  localparam int FRAME_PAD_W = FRAME_BITS - REG_ADDR_W - REG_DATA_W; // Leading zeros

  // Gain registers
  localparam logic [REG_ADDR_W-1:0] REG_RX_GAIN = 5'h09;
  localparam logic [REG_ADDR_W-1:0] REG_TX_GAIN = 5'h0A;

  localparam logic [3:0] TX_GAIN_PREFIX = 4'b0100; // Upper nibble of TX gain data
  localparam logic [1:0] RX_GAIN_PREFIX = 2'b01;   // Upper bits of RX gain data

  localparam logic [3:0] TX_GAIN_RESET = 4'hF;
  localparam logic [6:0] RX_GAIN_RESET = 7'h40;

  // One entry per codec address, write enable in bit 8
  localparam int INIT_LEN = 20;
  localparam logic [REG_DATA_W:0] INIT_TABLE [0:INIT_LEN-1] = '{
    {1'b0, 8'h00},  // 0x00 left at power-on value
    {1'b0, 8'h00},  // 0x01
    {1'b0, 8'h00},  // 0x02
    {1'b0, 8'h00},  // 0x03
    {1'b0, 8'h00},  // 0x04
    {1'b0, 8'h00},  // 0x05
    {1'b1, 8'h54},  // 0x06 clkout2 off
    {1'b1, 8'h30},  // 0x07 DC offset cal, RX filter on
    {1'b0, 8'h00},  // 0x08
    {1'b0, 8'h00},  // 0x09 RX gain, written by command
    {1'b0, 8'h00},  // 0x0A TX gain, written by command
    {1'b1, 8'h00},  // 0x0B RxPGA update source
    {1'b1, 8'h43},  // 0x0C TX twos complement, interpolation
    {1'b1, 8'h03},  // 0x0D RX twos complement
    {1'b1, 8'h81},  // 0x0E IAMP setting
    {1'b0, 8'h00},  // 0x0F
    {1'b1, 8'h80},  // 0x10 TX gain select
    {1'b1, 8'h00},  // 0x11 TX gain select
    {1'b1, 8'h00},  // 0x12
    {1'b0, 8'h00}   // 0x13
  };

endpackage

// File: rtl/spi_frame_shifter.sv
// 3-wire SPI shifter for the codec port
// One 16-bit word per frame, MSB first, sclk at half the clock rate
`timescale 1ns/1ps

module spi_frame_shifter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  frame_start,
  input  logic [codec_regs_pkg::FRAME_BITS-1:0] frame_word,
  output logic                                  busy,
  output logic                                  sen_n,
  output logic                                  sclk,
  output logic                                  sdio
);

  import codec_regs_pkg::*;

  typedef enum logic {S_IDLE, S_SHIFT} state_e;

  state_e                        state;
  logic [FRAME_BITS-1:0]         shreg;
  logic [$clog2(FRAME_BITS)-1:0] bit_cnt;  // Bits left after the current one

  assign busy  = (state == S_SHIFT);
  assign sen_n = (state != S_SHIFT);
  assign sdio  = busy & shreg[FRAME_BITS-1];  // Held low between frames

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      sclk    <= 1'b0;
      bit_cnt <= '1;
    end else begin
      case (state)
        S_IDLE: begin
          sclk    <= 1'b0;
          bit_cnt <= '1;
          if (frame_start) state <= S_SHIFT;
        end
        S_SHIFT: begin
          sclk <= ~sclk;                      // Codec samples on rising edge
          if (sclk) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0) state <= S_IDLE;  // 16th rising edge done
          end
        end
      endcase
    end
  end

  // Next bit goes out as sclk falls
  always_ff @(posedge clk) begin
    if (state == S_IDLE && frame_start)
      shreg <= frame_word;
    else if (state == S_SHIFT && sclk)
      shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the codec controller testbench with Verilator, runs it, checks the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
  --top-module tb_codec_ctrl -o sim_codec_ctrl > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_codec_ctrl +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/codec_ctrl_properties.sv
// Bound checks on the SPI and APB pins of the codec controller
`timescale 1ns/1ps

module codec_ctrl_properties (
  input logic clk,
  input logic rst,
  input logic pready,
  input logic pslverr,
  input logic sen_n,
  input logic sclk,
  input logic sdio
);

  int unsigned fail_cnt = 0;   // Failed checks so far
  logic [5:0]  low_cnt;        // Cycles sen_n has been low

  task automatic count_failure(input string msg);
    fail_cnt++;
    $error("%s", msg);
  endtask

  always_ff @(posedge clk) begin
    if (rst || sen_n)
      low_cnt <= '0;
    else
      low_cnt <= low_cnt + 1'b1;
  end

  reset_idle: assert property (@(posedge clk) $fell(rst) |-> (sen_n && !sclk))
    else count_failure("SPI pins not idle as reset releases");

  sclk_idle: assert property (@(posedge clk) disable iff (rst) sen_n |-> !sclk)
    else count_failure("sclk high while sen_n is high");

  // Data only moves on the low phase
  sdio_hold: assert property (@(posedge clk) disable iff (rst) sclk |-> $stable(sdio))
    else count_failure("sdio changed while sclk was high");

  frame_len: assert property (@(posedge clk) disable iff (rst) $rose(sen_n) |-> low_cnt == 6'd32)
    else count_failure("sen_n low period was not 32 cycles");

  err_ready: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
    else count_failure("pslverr without pready");

endmodule

// File: verification/tb_codec_ctrl.sv
// Testbench for the AD9866 serial port controller
// APB stimulus, SPI frame monitor with a reference model, error report
`timescale 1ns/1ps

module tb_codec_ctrl;

  localparam int WAIT_LIMIT = 3000;  // Cycles any one wait may take

  logic        clk, rst, psel, penable, pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata, prdata, rdata, rnd;
  logic        pready, pslverr, sen_n, sclk, sdio;
  logic [15:0] exp_q[$];             // Predicted frames in arrival order
  logic [15:0] shift_word;
  logic [3:0]  tx_model;             // Gains the codec should hold
  logic [6:0]  rx_model;
  logic        aborted;              // Set once a wait runs out
  int          bit_cnt, waited, mismatch_cnt, other_cnt;

  codec_ctrl_top codec_ctrl_top_inst (.*);
  bind codec_ctrl_top codec_ctrl_properties codec_ctrl_properties_inst (
    .clk(clk), .rst(rst), .pready(pready), .pslverr(pslverr),
    .sen_n(sen_n), .sclk(sclk), .sdio(sdio));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Frame monitor collects 16 sdio bits per word
  always @(posedge sclk) begin
    shift_word = {shift_word[14:0], sdio};
    bit_cnt    = bit_cnt + 1;
    if (bit_cnt == 16) begin
      bit_cnt = 0;
      assert (exp_q.size() > 0) else begin
        other_cnt++;
        $display("SPI frame %h arrived while no frame was expected", shift_word);
      end
      if (exp_q.size() > 0) begin
        assert (shift_word == exp_q[0]) else begin
          mismatch_cnt++;
          $display("Mismatch frame_word expected %h got %h", exp_q[0], shift_word);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // Codec PGA code for a 7-bit RX gain
  function automatic logic [5:0] rx_code(input logic [6:0] g);
    if (g[6]) return g[5:0];
    else if (g[5]) return ~g[5:0];
    else return {1'b1, g[4:0]};
  endfunction

  task automatic finish_run();
    int asrt_cnt;
    asrt_cnt = codec_ctrl_top_inst.codec_ctrl_properties_inst.fail_cnt;
    $display("Errors: %0d mismatch, %0d other, %0d assertion",
             mismatch_cnt, other_cnt, asrt_cnt);
    if (mismatch_cnt + other_cnt + asrt_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  endtask

  // One APB transfer with no wait states allowed when instant is set
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            input logic exp_err, input logic instant);
    if (aborted) return;
    @(posedge clk);
    psel   <= 1'b1;
    pwrite <= wr;
    paddr  <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;              // Access phase
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!pready && waited < WAIT_LIMIT);
    if (!pready) begin
      other_cnt++;
      aborted = 1'b1;
      $display("APB access to offset %h never got pready", addr);
    end else begin
      rdata = prdata;
      assert (pslverr == exp_err) else begin
        mismatch_cnt++;
        $display("Mismatch pslverr expected %h got %h", exp_err, pslverr);
      end
      assert (!instant || waited == 1) else begin
        other_cnt++;
        $display("Access to offset %h took %0d wait states, none expected", addr, waited - 1);
      end
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  // Until every predicted frame is seen and sen_n is high again
  task automatic wait_drain();
    int n;
    if (aborted) return;
    n = 0;
    while ((exp_q.size() > 0 || !sen_n) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0 || !sen_n) begin
      other_cnt++;
      aborted = 1'b1;
      $display("Frame shortfall, %0d predicted SPI frames never appeared", exp_q.size());
    end
  endtask

  task automatic expect_quiet();
    logic quiet;
    quiet = 1'b1;
    for (int i = 0; i < 60; i++) begin
      @(negedge clk);
      if (!sen_n) quiet = 1'b0;
    end
    assert (quiet) else begin
      other_cnt++;
      $display("SPI traffic after an access that should send no frame");
    end
  endtask

  // Unchanged gains send nothing and finish at once
  task automatic gain_write(input logic is_rx, input logic [6:0] g);
    logic same;
    same = is_rx ? (g == rx_model) : (g[3:0] == tx_model);
    if (!same && is_rx) exp_q.push_back({3'b000, 5'h09, 2'b01, rx_code(g)});
    if (!same && !is_rx) exp_q.push_back({3'b000, 5'h0A, 4'b0100, g[3:0]});
    if (is_rx) rx_model = g;
    else tx_model = g[3:0];
    apb_access(1'b1, is_rx ? 4'h4 : 4'h0, {25'd0, g}, 1'b0, same);
  endtask

  task automatic raw_write(input logic [4:0] a, input logic [7:0] d);
    exp_q.push_back({3'b000, a, d});
    apb_access(1'b1, 4'h8, {19'd0, a, d}, 1'b0, 1'b0);
  endtask

  initial begin
    rnd = $urandom(69);
    rst = 1'b1;
    {psel, penable, pwrite} = 3'b000;
    paddr = '0;
    pwdata = '0;
    rdata = '0;
    shift_word = '0;
    bit_cnt = 0;
    mismatch_cnt = 0;
    other_cnt = 0;
    aborted = 1'b0;
    tx_model = 4'hF;
    rx_model = 7'h40;
    // Init writes with the codec address in the high byte
    exp_q = '{16'h0654, 16'h0730, 16'h0B00, 16'h0C43, 16'h0D03,
              16'h0E81, 16'h1080, 16'h1100, 16'h1200};
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait_drain();
    for (int i = 0; i < 10 && !rdata[0]; i++)
      apb_access(1'b0, 4'hC, 32'd0, 1'b0, 1'b1);
    assert (rdata == 32'h1) else begin
      mismatch_cnt++;
      $display("Mismatch prdata expected %h got %h", 32'h1, rdata);
    end
    gain_write(1'b0, 7'h0F);          // Same as reset value
    rnd = $urandom % 15;
    gain_write(1'b0, {3'd0, rnd[3:0]});
    wait_drain();
    gain_write(1'b0, {3'd0, rnd[3:0]});
    rnd = $urandom;
    gain_write(1'b1, {1'b1, rnd[5:1], 1'b1}); // Direct code kept odd to differ from reset
    gain_write(1'b1, {2'b01, rnd[12:8]});   // Inverted code
    gain_write(1'b1, {2'b00, rnd[20:16]});  // Leading one
    wait_drain();
    gain_write(1'b1, {2'b00, rnd[20:16]});
    rnd = $urandom;
    raw_write(rnd[12:8], rnd[7:0]);
    raw_write(rnd[20:16], rnd[31:24]);
    assert (waited > 1) else begin
      other_cnt++;
      $display("Back-to-back raw write was not held off by pready");
    end
    raw_write(rnd[4:0], rnd[23:16]);
    wait_drain();
    apb_access(1'b1, 4'hC, 32'h3, 1'b1, 1'b1);
    apb_access(1'b1, 4'h2, 32'h1234, 1'b1, 1'b1);
    apb_access(1'b0, 4'h6, 32'd0, 1'b1, 1'b1);
    expect_quiet();
    wait_drain();
    finish_run();
  end

endmodule
